// File: common/tcb_lite_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared TCB-Lite types, little-endian data only
// the 8-byte size code is only legal on a 64-bit bus
////////////////////////////////////////////////////////////////////////////

package tcb_lite_pkg;

    ////////////////////////////////////////////////////////////////////////
    // bus mode
    ////////////////////////////////////////////////////////////////////////

    // how a request selects its bytes
    // LOG_SIZE: power of two size, data sits in the low lanes
    // BYTE_EN: one enable bit per lane, data sits in place
    typedef enum logic {
        LOG_SIZE = 1'b0,
        BYTE_EN  = 1'b1
    } tcb_bus_mode_e;

    ////////////////////////////////////////////////////////////////////////
    // register slice optimization
    ////////////////////////////////////////////////////////////////////////

    // POWER loads only the write data lanes that a transfer uses
    // COMPLEXITY loads the full word on every write
    typedef enum logic {
        POWER      = 1'b0,
        COMPLEXITY = 1'b1
    } tcb_opt_e;

    ////////////////////////////////////////////////////////////////////////
    // transfer size
    ////////////////////////////////////////////////////////////////////////

    // number of bytes is 2**siz
    // 0 byte
    // 1 halfword
    // 2 word
    // 3 doubleword, wide bus only
    typedef logic [1:0] tcb_siz_t;

endpackage : tcb_lite_pkg

// File: hw/tcb_lite_register_request.sv
////////////////////////////////////////////////////////////////////////////
// request path register slice, adds one cycle of request latency
// no bubble, ready only depends on the downstream side and out_vld
////////////////////////////////////////////////////////////////////////////

module tcb_lite_register_request #(
    parameter int                          DAT_WIDTH = 32,
    parameter int                          ADR_WIDTH = 12,
    parameter tcb_lite_pkg::tcb_bus_mode_e MOD       = tcb_lite_pkg::LOG_SIZE,
    parameter tcb_lite_pkg::tcb_opt_e      OPT       = tcb_lite_pkg::POWER
) (
    input  logic                   sub,
    input  logic                   reset,
    // manager side
    input  logic                   in_vld,
    input  logic                   in_wen,
    input  logic                   in_ren,
    input  logic [ADR_WIDTH-1:0]   in_adr,
    input  tcb_lite_pkg::tcb_siz_t in_siz,
    input  logic [DAT_WIDTH/8-1:0] in_byt,
    input  logic [DAT_WIDTH-1:0]   in_wdt,
    output logic                   in_rdy,
    // subordinate side
    output logic                   out_vld,
    output logic                   out_wen,
    output logic                   out_ren,
    output logic [ADR_WIDTH-1:0]   out_adr,
    output tcb_lite_pkg::tcb_siz_t out_siz,
    output logic [DAT_WIDTH/8-1:0] out_byt,
    output logic [DAT_WIDTH-1:0]   out_wdt,
    input  logic                   out_rdy
);

    import tcb_lite_pkg::*;

    localparam int BYT = DAT_WIDTH/8;

    // transfer on the manager side
    logic in_trn;

    // slice is free when empty or when its content leaves this cycle
    assign in_rdy = out_rdy | ~out_vld;
    assign in_trn = in_vld & in_rdy;

    ////////////////////////////////////////////////////////////////////////
    // handshake and request fields
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge sub) begin
        if (reset) begin
            out_vld <= 1'b0;
        end else if (in_rdy) begin
            out_vld <= in_vld;
        end
    end

    // payload, no reset
    always_ff @(posedge sub) begin
        if (in_trn) begin
            out_wen <= in_wen;
            out_ren <= in_ren;
            out_adr <= in_adr;
            out_siz <= in_siz;
            out_byt <= in_byt;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // write data
    ////////////////////////////////////////////////////////////////////////

    generate
        if (OPT == POWER) begin : g_power
            // unused lanes keep their old value, fewer flops toggle
            for (genvar i = 0; i < BYT; i++) begin : g_lane
                logic lane_use;

                if (MOD == LOG_SIZE) begin : g_log
                    // lanes below 2**siz
                    assign lane_use = (i < (1 << in_siz));
                end else begin : g_byt
                    assign lane_use = in_byt[i];
                end

                always_ff @(posedge sub) begin
                    if (in_trn && in_wen && lane_use) begin
                        out_wdt[i*8 +: 8] <= in_wdt[i*8 +: 8];
                    end
                end
            end
        end else begin : g_complexity
            // whole word, single enable
            always_ff @(posedge sub) begin
                if (in_trn && in_wen) begin
                    out_wdt <= in_wdt;
                end
            end
        end
    endgenerate

    // stalled request must stay put until accepted
    property p_req_hold;
        @(posedge sub) disable iff (reset)
        (in_vld && !in_rdy) |=>
            (in_vld && $stable({in_wen, in_ren, in_adr, in_siz, in_byt, in_wdt}));
    endproperty

    a_req_hold : assert property (p_req_hold)
        else $error("request changed while stalled");

endmodule : tcb_lite_register_request

// File: tcb_mem/tcb_mem_decode.sv
////////////////////////////////////////////////////////////////////////////
// combinational request decode, error only flagged on an access
// acc_idx is truncated to the memory depth, acc_err covers the range check
////////////////////////////////////////////////////////////////////////////

module tcb_mem_decode #(
    parameter int                          DAT_WIDTH = 32,
    parameter int                          ADR_WIDTH = 12,
    parameter int                          MEM_DEPTH = 256,
    parameter tcb_lite_pkg::tcb_bus_mode_e MOD       = tcb_lite_pkg::LOG_SIZE
) (
    input  logic                             vld,
    input  logic                             wen,
    input  logic                             ren,
    input  logic [ADR_WIDTH-1:0]             adr,
    input  tcb_lite_pkg::tcb_siz_t           siz,
    input  logic [DAT_WIDTH/8-1:0]           byt,
    input  logic [DAT_WIDTH-1:0]             wdt,
    output logic                             acc_ena,
    output logic                             acc_wen,
    output logic [$clog2(MEM_DEPTH)-1:0]     acc_idx,
    output logic [DAT_WIDTH/8-1:0]           acc_msk,
    output logic [DAT_WIDTH-1:0]             acc_wdt,
    output logic                             acc_err,
    output logic [$clog2(DAT_WIDTH/8)-1:0]   acc_sft
);

    import tcb_lite_pkg::*;

    localparam int BYT   = DAT_WIDTH/8;
    localparam int OFF_W = $clog2(BYT);
    localparam int IDX_W = $clog2(MEM_DEPTH);

    // word address and byte offset
    logic [ADR_WIDTH-OFF_W-1:0] wrd;
    logic [OFF_W-1:0]           off;
    // range and format errors
    logic                       rng_err;
    logic                       fmt_err;

    assign off = adr[OFF_W-1:0];
    assign wrd = adr[ADR_WIDTH-1:OFF_W];

    assign rng_err = (32'(wrd) >= MEM_DEPTH);

    assign acc_ena = vld & (wen | ren);
    assign acc_wen = wen;
    assign acc_idx = wrd[IDX_W-1:0];
    assign acc_sft = off;
    assign acc_err = acc_ena & (rng_err | fmt_err);

    generate
        if (MOD == LOG_SIZE) begin : g_log
            // lanes used before shifting to the offset
            logic [BYT-1:0] siz_msk;

            always_comb begin
                siz_msk = '0;
                fmt_err = 1'b0;
                for (int i = 0; i < BYT; i++) begin
                    siz_msk[i] = (i < (1 << siz));
                end
                // offset bits below siz must be zero
                for (int i = 0; i < OFF_W; i++) begin
                    fmt_err = fmt_err | (off[i] & (i < int'(siz)));
                end
            end

            // move low lane data up to its offset
            assign acc_msk = siz_msk << off;
            assign acc_wdt = wdt << (8 * off);

            // manager must not ask for more than the bus carries
            always_comb begin
                if (vld) begin
                    a_siz_fit : assert ((1 << siz) <= BYT)
                        else $error("size exceeds bus width");
                end
            end
        end else begin : g_byt
            // data and mask already in place
            assign acc_msk = byt;
            assign acc_wdt = wdt;
            // access with no lanes enabled
            assign fmt_err = ~|byt;
        end
    endgenerate

endmodule : tcb_mem_decode

// File: tcb_mem/tcb_mem_execute.sv
////////////////////////////////////////////////////////////////////////////
// single port word array, one cycle read, contents undefined after reset
////////////////////////////////////////////////////////////////////////////

module tcb_mem_execute #(
    parameter int DAT_WIDTH = 32,
    parameter int MEM_DEPTH = 256
) (
    input  logic                           sub,
    input  logic                           reset,
    // decoded access
    input  logic                           acc_ena,
    input  logic                           acc_wen,
    input  logic [$clog2(MEM_DEPTH)-1:0]   acc_idx,
    input  logic [DAT_WIDTH/8-1:0]         acc_msk,
    input  logic [DAT_WIDTH-1:0]           acc_wdt,
    input  logic                           acc_err,
    input  logic [$clog2(DAT_WIDTH/8)-1:0] acc_sft,
    // registered result
    output logic                           rd_vld,
    output logic [DAT_WIDTH-1:0]           rd_dat,
    output logic                           rd_err,
    output logic [$clog2(DAT_WIDTH/8)-1:0] rd_sft,
    output logic                           rd_wen
);

    localparam int BYT = DAT_WIDTH/8;

    // storage
    logic [DAT_WIDTH-1:0] mem [MEM_DEPTH];

    // byte lane writes, skipped on error
    always_ff @(posedge sub) begin
        if (acc_ena && acc_wen && !acc_err) begin
            for (int i = 0; i < BYT; i++) begin
                if (acc_msk[i]) begin
                    mem[acc_idx][i*8 +: 8] <= acc_wdt[i*8 +: 8];
                end
            end
        end
    end

    // read whole word, lane selection happens in result
    always_ff @(posedge sub) begin
        if (acc_ena && !acc_wen && !acc_err) begin
            rd_dat <= mem[acc_idx];
        end
    end

    // response info, one stage behind the access
    always_ff @(posedge sub) begin
        if (reset) begin
            rd_vld <= 1'b0;
            rd_err <= 1'b0;
            rd_wen <= 1'b0;
        end else begin
            rd_vld <= acc_ena;
            rd_err <= acc_err;
            rd_wen <= acc_wen;
        end
    end

    // offset only matters for reads
    always_ff @(posedge sub) begin
        if (acc_ena) begin
            rd_sft <= acc_sft;
        end
    end

    // decode must flag every index past the array
    a_idx_range : assert property (
        @(posedge sub) disable iff (reset)
        (acc_ena && !acc_err) |-> (32'(acc_idx) < MEM_DEPTH)
    ) else $error("index out of range without error");

endmodule : tcb_mem_execute

// File: tcb_mem/tcb_mem_result.sv
////////////////////////////////////////////////////////////////////////////
// response output, zero data on writes, errors and idle cycles
////////////////////////////////////////////////////////////////////////////

module tcb_mem_result #(
    parameter int                          DAT_WIDTH = 32,
    parameter tcb_lite_pkg::tcb_bus_mode_e MOD       = tcb_lite_pkg::LOG_SIZE
) (
    input  logic                           rd_vld,
    input  logic [DAT_WIDTH-1:0]           rd_dat,
    input  logic                           rd_err,
    input  logic [$clog2(DAT_WIDTH/8)-1:0] rd_sft,
    input  logic                           rd_wen,
    output logic [DAT_WIDTH-1:0]           rsp_rdt,
    output logic                           rsp_err
);

    import tcb_lite_pkg::*;

    // read data in bus lane order
    logic [DAT_WIDTH-1:0] rdt_aln;
    // good read response
    logic                 rdt_ena;

    generate
        if (MOD == LOG_SIZE) begin : g_log
            // bring addressed bytes down to lane 0
            assign rdt_aln = rd_dat >> (8 * rd_sft);
        end else begin : g_byt
            assign rdt_aln = rd_dat;
        end
    endgenerate

    assign rdt_ena = rd_vld & ~rd_err & ~rd_wen;

    assign rsp_rdt = rdt_ena ? rdt_aln : '0;
    assign rsp_err = rd_vld & rd_err;

endmodule : tcb_mem_result

// File: hw/tcb_mem_top.sv
////////////////////////////////////////////////////////////////////////////
// TCB-Lite memory, fixed response delay of 2 cycles after each transfer
// memory side never stalls, so in_rdy stays high after reset
////////////////////////////////////////////////////////////////////////////

module tcb_mem_top #(
    parameter int                          DAT_WIDTH = 32,
    parameter int                          ADR_WIDTH = 12,
    parameter int                          MEM_DEPTH = 256,
    parameter tcb_lite_pkg::tcb_bus_mode_e MOD       = tcb_lite_pkg::LOG_SIZE,
    parameter tcb_lite_pkg::tcb_opt_e      OPT       = tcb_lite_pkg::POWER
) (
    input  logic                   sub,
    input  logic                   reset,
    // request
    input  logic                   in_vld,
    input  logic                   in_wen,
    input  logic                   in_ren,
    input  logic [ADR_WIDTH-1:0]   in_adr,
    input  tcb_lite_pkg::tcb_siz_t in_siz,
    input  logic [DAT_WIDTH/8-1:0] in_byt,
    input  logic [DAT_WIDTH-1:0]   in_wdt,
    output logic                   in_rdy,
    // response
    output logic [DAT_WIDTH-1:0]   rsp_rdt,
    output logic                   rsp_err
);

    import tcb_lite_pkg::*;

    localparam int BYT   = DAT_WIDTH/8;
    localparam int OFF_W = $clog2(BYT);
    localparam int IDX_W = $clog2(MEM_DEPTH);

    ////////////////////////////////////////////////////////////////////////
    // interconnect
    ////////////////////////////////////////////////////////////////////////

    // slice outputs
    logic                 out_vld;
    logic                 out_wen;
    logic                 out_ren;
    logic [ADR_WIDTH-1:0] out_adr;
    tcb_siz_t             out_siz;
    logic [BYT-1:0]       out_byt;
    logic [DAT_WIDTH-1:0] out_wdt;

    // decoded access
    logic                 acc_ena;
    logic                 acc_wen;
    logic [IDX_W-1:0]     acc_idx;
    logic [BYT-1:0]       acc_msk;
    logic [DAT_WIDTH-1:0] acc_wdt;
    logic                 acc_err;
    logic [OFF_W-1:0]     acc_sft;

    // memory result
    logic                 rd_vld;
    logic [DAT_WIDTH-1:0] rd_dat;
    logic                 rd_err;
    logic [OFF_W-1:0]     rd_sft;
    logic                 rd_wen;

    ////////////////////////////////////////////////////////////////////////
    // blocks
    ////////////////////////////////////////////////////////////////////////

    // memory accepts every cycle, out_rdy tied high
    tcb_lite_register_request #(
        .DAT_WIDTH (DAT_WIDTH),
        .ADR_WIDTH (ADR_WIDTH),
        .MOD       (MOD),
        .OPT       (OPT)
    ) u_slice (
        .sub     (sub),
        .reset   (reset),
        .in_vld  (in_vld),
        .in_wen  (in_wen),
        .in_ren  (in_ren),
        .in_adr  (in_adr),
        .in_siz  (in_siz),
        .in_byt  (in_byt),
        .in_wdt  (in_wdt),
        .in_rdy  (in_rdy),
        .out_vld (out_vld),
        .out_wen (out_wen),
        .out_ren (out_ren),
        .out_adr (out_adr),
        .out_siz (out_siz),
        .out_byt (out_byt),
        .out_wdt (out_wdt),
        .out_rdy (1'b1)
    );

    tcb_mem_decode #(
        .DAT_WIDTH (DAT_WIDTH),
        .ADR_WIDTH (ADR_WIDTH),
        .MEM_DEPTH (MEM_DEPTH),
        .MOD       (MOD)
    ) u_decode (
        .vld     (out_vld),
        .wen     (out_wen),
        .ren     (out_ren),
        .adr     (out_adr),
        .siz     (out_siz),
        .byt     (out_byt),
        .wdt     (out_wdt),
        .acc_ena (acc_ena),
        .acc_wen (acc_wen),
        .acc_idx (acc_idx),
        .acc_msk (acc_msk),
        .acc_wdt (acc_wdt),
        .acc_err (acc_err),
        .acc_sft (acc_sft)
    );

    tcb_mem_execute #(
        .DAT_WIDTH (DAT_WIDTH),
        .MEM_DEPTH (MEM_DEPTH)
    ) u_execute (
        .sub     (sub),
        .reset   (reset),
        .acc_ena (acc_ena),
        .acc_wen (acc_wen),
        .acc_idx (acc_idx),
        .acc_msk (acc_msk),
        .acc_wdt (acc_wdt),
        .acc_err (acc_err),
        .acc_sft (acc_sft),
        .rd_vld  (rd_vld),
        .rd_dat  (rd_dat),
        .rd_err  (rd_err),
        .rd_sft  (rd_sft),
        .rd_wen  (rd_wen)
    );

    tcb_mem_result #(
        .DAT_WIDTH (DAT_WIDTH),
        .MOD       (MOD)
    ) u_result (
        .rd_vld  (rd_vld),
        .rd_dat  (rd_dat),
        .rd_err  (rd_err),
        .rd_sft  (rd_sft),
        .rd_wen  (rd_wen),
        .rsp_rdt (rsp_rdt),
        .rsp_err (rsp_err)
    );

endmodule : tcb_mem_top

// File: sim/tcb_mem_tb.sv
////////////////////////////////////////////////////////////////////////////
// table rows then a random burst of aligned accesses
// each response is checked 2 cycles after its transfer
// MODE selects log size (0) or byte enable (1) on a 32-bit bus only
////////////////////////////////////////////////////////////////////////////

module tcb_mem_tb #(
    parameter int MODE = 0
);

    import tcb_lite_pkg::*;

    localparam int            DAT_WIDTH = 32;
    localparam int            ADR_WIDTH = 12;
    localparam int            MEM_DEPTH = 256;
    localparam int            BYT       = DAT_WIDTH/8;
    localparam tcb_bus_mode_e MOD       = tcb_bus_mode_e'(MODE);
    localparam int            SEED      = 29067;
    localparam int            TBL_LEN   = 21;
    localparam int            BURST_LEN = 64;
    // response delay in cycles
    localparam int            RSP_DLY   = 2;
    // cycles allowed before the run is called stuck
    localparam int            LIMIT     = (TBL_LEN + BURST_LEN) * 4 + 50;

    // one table row with wdt holding the bytes in place
    typedef struct packed {
        bit                   wr;
        logic [ADR_WIDTH-1:0] adr;
        tcb_siz_t             siz;
        logic [BYT-1:0]       byt;
        logic [DAT_WIDTH-1:0] wdt;
        bit                   err;
    } row_t;

    // expected response where tag -1 marks an idle slot
    typedef struct packed {
        int                   tag;
        logic [DAT_WIDTH-1:0] rdt;
        bit                   err;
    } exp_t;

    ////////////////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////////////////

    //  wr    adr      siz   byt   wdt in place    err
    row_t tbl [TBL_LEN] = '{
        '{1'b1, 12'h000, 2'd2, 4'hf, 32'h1122_3344, 1'b0},
        '{1'b1, 12'h004, 2'd2, 4'hf, 32'h5566_7788, 1'b0},
        '{1'b1, 12'h008, 2'd2, 4'hf, 32'h99aa_bbcc, 1'b0},
        '{1'b1, 12'h00c, 2'd2, 4'hf, 32'hddee_ff00, 1'b0},
        '{1'b0, 12'h000, 2'd2, 4'hf, 32'h0000_0000, 1'b0},
        '{1'b0, 12'h004, 2'd2, 4'hf, 32'h0000_0000, 1'b0},
        '{1'b0, 12'h008, 2'd2, 4'hf, 32'h0000_0000, 1'b0},
        '{1'b0, 12'h00c, 2'd2, 4'hf, 32'h0000_0000, 1'b0},
        // sub-word writes
        '{1'b1, 12'h001, 2'd0, 4'h2, 32'h0000_5a00, 1'b0},
        '{1'b1, 12'h00a, 2'd1, 4'hc, 32'hbeef_0000, 1'b0},
        '{1'b1, 12'h00f, 2'd0, 4'h8, 32'h7700_0000, 1'b0},
        '{1'b0, 12'h001, 2'd0, 4'h2, 32'h0000_0000, 1'b0},
        '{1'b0, 12'h00a, 2'd1, 4'hc, 32'h0000_0000, 1'b0},
        '{1'b0, 12'h00c, 2'd2, 4'hf, 32'h0000_0000, 1'b0},
        // misaligned or empty mask then a read back of the word
        '{1'b1, 12'h006, 2'd2, 4'h0, 32'hdead_dead, 1'b1},
        '{1'b0, 12'h004, 2'd2, 4'hf, 32'h0000_0000, 1'b0},
        '{1'b0, 12'h003, 2'd1, 4'h0, 32'h0000_0000, 1'b1},
        // out of range index that would wrap onto word 0
        '{1'b1, 12'h400, 2'd2, 4'hf, 32'hcafe_f00d, 1'b1},
        '{1'b0, 12'h000, 2'd2, 4'hf, 32'h0000_0000, 1'b0},
        '{1'b0, 12'hffc, 2'd2, 4'hf, 32'h0000_0000, 1'b1},
        '{1'b0, 12'h002, 2'd1, 4'hc, 32'h0000_0000, 1'b0}
    };

    // DUT ports
    logic                 sub = 1'b0;
    logic                 reset;
    logic                 in_vld;
    logic                 in_wen;
    logic                 in_ren;
    logic [ADR_WIDTH-1:0] in_adr;
    tcb_siz_t             in_siz;
    logic [BYT-1:0]       in_byt;
    logic [DAT_WIDTH-1:0] in_wdt;
    logic                 in_rdy;
    logic [DAT_WIDTH-1:0] rsp_rdt;
    logic                 rsp_err;

    // shadow memory with one entry per byte
    logic [7:0] shadow [MEM_DEPTH*BYT];
    // responses in flight
    exp_t       pipe [$];
    int         n_chk = 0;
    int         n_err = 0;
    int         n_cyc = 0;

    tcb_mem_top #(
        .DAT_WIDTH (DAT_WIDTH),
        .ADR_WIDTH (ADR_WIDTH),
        .MEM_DEPTH (MEM_DEPTH),
        .MOD       (MOD),
        .OPT       (POWER)
    ) dut (
        .sub     (sub),
        .reset   (reset),
        .in_vld  (in_vld),
        .in_wen  (in_wen),
        .in_ren  (in_ren),
        .in_adr  (in_adr),
        .in_siz  (in_siz),
        .in_byt  (in_byt),
        .in_wdt  (in_wdt),
        .in_rdy  (in_rdy),
        .rsp_rdt (rsp_rdt),
        .rsp_err (rsp_err)
    );

    always #4 sub = ~sub;

    // stuck run guard
    always @(posedge sub) begin
        n_cyc <= n_cyc + 1;
        if (n_cyc >= LIMIT) begin
            $display("timeout: run still going after %0d cycles", LIMIT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////

    function automatic string tag_name(input int tag);
        if (tag < 0) begin
            return "idle";
        end
        if (tag < TBL_LEN) begin
            return $sformatf("row %0d", tag);
        end
        return $sformatf("burst %0d", tag - TBL_LEN);
    endfunction

    task automatic check_rdt(input int tag, input logic [DAT_WIDTH-1:0] got,
                             input logic [DAT_WIDTH-1:0] want);
        n_chk++;
        if (got !== want) begin
            n_err++;
            $display("Fail t=%0t %s: rsp_rdt %h, expected %h",
                     $time, tag_name(tag), got, want);
        end else begin
            $display("ok   %s: rsp_rdt %h", tag_name(tag), got);
        end
    endtask

    task automatic check_err(input int tag, input bit got, input bit want);
        n_chk++;
        if (got !== want) begin
            n_err++;
            $display("Fail t=%0t %s: rsp_err %b, expected %b",
                     $time, tag_name(tag), got, want);
        end else begin
            $display("ok   %s: rsp_err %b", tag_name(tag), got);
        end
    endtask

    task automatic check_rdy(input bit got);
        n_chk++;
        if (got !== 1'b1) begin
            n_err++;
            $display("Fail t=%0t in_rdy %b, expected 1", $time, got);
        end else begin
            $display("ok   in_rdy high");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // drive
    ////////////////////////////////////////////////////////////////////////

    // on the falling edge retire the response due now and queue the new one
    task automatic next_cycle(input exp_t e);
        exp_t old;
        @(negedge sub);
        if (pipe.size() >= RSP_DLY) begin
            old = pipe.pop_front();
            check_rdt(old.tag, rsp_rdt, old.rdt);
            check_err(old.tag, rsp_err, old.err);
        end
        pipe.push_back(e);
    endtask

    task automatic idle_cycle();
        exp_t e;
        e.tag = -1;
        e.rdt = '0;
        e.err = 1'b0;
        next_cycle(e);
        in_vld = 1'b0;
        in_wen = 1'b0;
        in_ren = 1'b0;
    endtask

    // one transfer with its expected response from the shadow memory
    task automatic apply(input int tag, input bit wr, input logic [ADR_WIDTH-1:0] adr,
                         input tcb_siz_t siz, input logic [BYT-1:0] byt,
                         input logic [DAT_WIDTH-1:0] wdt, input bit err);
        exp_t                 e;
        int                   idx;
        int                   off;
        int                   msk;
        logic [DAT_WIDTH-1:0] word;
        idx = int'(adr) / BYT;
        off = int'(adr) % BYT;
        // lanes touched by size from the offset or by enables
        if (MOD == LOG_SIZE) begin
            msk = ((1 << (1 << siz)) - 1) << off;
        end else begin
            msk = int'(byt);
        end
        e.tag = tag;
        e.err = err;
        e.rdt = '0;
        if (!err && wr) begin
            for (int j = 0; j < BYT; j++) begin
                if (msk[j]) begin
                    shadow[idx*BYT + j] = wdt[j*8 +: 8];
                end
            end
        end else if (!err) begin
            for (int j = 0; j < BYT; j++) begin
                word[j*8 +: 8] = shadow[idx*BYT + j];
            end
            // log size reads come back in the low lanes
            e.rdt = (MOD == LOG_SIZE) ? word >> (8 * off) : word;
        end
        next_cycle(e);
        in_vld = 1'b1;
        in_wen = wr;
        in_ren = !wr;
        in_adr = adr;
        in_siz = siz;
        in_byt = byt;
        in_wdt = (MOD == LOG_SIZE) ? wdt >> (8 * off) : wdt;
    endtask

    ////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////

    initial begin
        exp_t                 blank;
        bit                   wr;
        int                   idx;
        int                   siz_i;
        int                   off;
        int                   b_msk;
        logic [ADR_WIDTH-1:0] adr;
        logic [DAT_WIDTH-1:0] wdt;
        void'($urandom(SEED));
        reset  = 1'b1;
        in_vld = 1'b0;
        in_wen = 1'b0;
        in_ren = 1'b0;
        in_adr = '0;
        in_siz = '0;
        in_byt = '0;
        in_wdt = '0;
        repeat (10) @(negedge sub);
        reset = 1'b0;
        check_rdy(in_rdy);
        // nothing in flight yet so the first slots must read zero
        blank.tag = -1;
        blank.rdt = '0;
        blank.err = 1'b0;
        repeat (RSP_DLY) pipe.push_back(blank);
        // table rows back to back
        for (int i = 0; i < TBL_LEN; i++) begin
            apply(i, tbl[i].wr, tbl[i].adr, tbl[i].siz, tbl[i].byt, tbl[i].wdt, tbl[i].err);
        end
        // burst over words 0 to 15 that are filled with full words first
        for (int i = 0; i < BURST_LEN; i++) begin
            if (i < 16) begin
                wr    = 1'b1;
                idx   = i;
                siz_i = 2;
            end else begin
                wr    = ($urandom_range(0, 1) == 1);
                idx   = $urandom_range(0, 15);
                siz_i = $urandom_range(0, 2);
            end
            // aligned offset
            off   = ($urandom_range(0, BYT - 1) >> siz_i) << siz_i;
            b_msk = ((1 << (1 << siz_i)) - 1) << off;
            adr   = ADR_WIDTH'(idx * BYT + off);
            wdt   = $urandom();
            apply(TBL_LEN + i, wr, adr, tcb_siz_t'(siz_i), b_msk[BYT-1:0], wdt, 1'b0);
        end
        // drain the last responses
        repeat (RSP_DLY) idle_cycle();
        check_rdy(in_rdy);
        $display("checks %0d, errors %0d", n_chk, n_err);
        if (n_err == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : tcb_mem_tb

// File: tcb_mem.f
common/tcb_lite_pkg.sv
hw/tcb_lite_register_request.sv
tcb_mem/tcb_mem_decode.sv
tcb_mem/tcb_mem_execute.sv
tcb_mem/tcb_mem_result.sv
hw/tcb_mem_top.sv
sim/tcb_mem_tb.sv

// File: Makefile
# Verilator build, sim runs the testbench in both bus modes

TOP = tcb_mem_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tcb_mem.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tcb_mem.f --top-module $(TOP) \
		-GMODE=0 --Mdir obj_log -o sim_log
	./obj_log/sim_log | tee sim_log.log
	grep -q "PASS: all tests" sim_log.log
	verilator --binary --timing --assert -f tcb_mem.f --top-module $(TOP) \
		-GMODE=1 --Mdir obj_byt -o sim_byt
	./obj_byt/sim_byt | tee sim_byt.log
	grep -q "PASS: all tests" sim_byt.log

clean:
	rm -rf obj_log obj_byt sim_log.log sim_byt.log
